/* Makefile */
# Verilator flow for the FIR filter testbench
VERILATOR ?= verilator
TOP       ?= fir_filter_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) rtl/weights.mem
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The binary exits non-zero on $$fatal, so the log decides the result
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
rtl/fir_num_pkg.sv
rtl/fir_ctl_pkg.sv
rtl/fir_sample_ram.sv
rtl/fir_coef_rom.sv
rtl/fir_mac_tap.sv
rtl/fir_seq_ctrl.sv
rtl/fir_filter_top.sv
tests/fir_filter_chk.sv
tests/fir_filter_tb.sv

/* rtl/fir_coef_rom.sv */
module fir_coef_rom (
    input  logic                                  i_clk,
    input  logic                                  i_re,
    input  logic [fir_num_pkg::ADDR_W-1:0]        i_addr,
    output logic signed [fir_num_pkg::COEF_W-1:0] o_coef
);
    import fir_num_pkg::*;

    logic signed [COEF_W-1:0] rom [FIR_DEPTH];  // h[0] first, one word per line in the file

    // Contents fixed at elaboration
    initial begin
        $readmemh(COEF_FILE, rom);
    end

    // Same one-cycle latency as the sample RAM, so both words land together
    always_ff @(posedge i_clk) begin
        if (i_re) begin
            o_coef <= rom[i_addr];
        end
    end

endmodule

/* rtl/fir_ctl_pkg.sv */
package fir_ctl_pkg;

    // Sequencer states, one sample per pass
    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,  // Waiting for a held sample
        S_WRITE = 3'd1,  // Held sample goes into the history
        S_TAPS  = 3'd2,  // One tap per cycle
        S_DRAIN = 3'd3,  // Memory and MAC pipeline empty out
        S_EMIT  = 3'd4   // Result waits for an output credit
    } seq_state_t;

    // Source credits after reset, matches the one-entry holding register
    localparam int IN_CREDITS = 1;

    // Most output credits the sink may have outstanding
    localparam int OUT_CREDITS = 4;
    localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);

endpackage

/* rtl/fir_filter_top.sv */
module fir_filter_top (
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  logic                                  i_din_valid,
    input  logic signed [fir_num_pkg::DATA_W-1:0] i_din,
    output logic                                  o_in_credit,
    input  logic                                  i_out_credit,
    output logic                                  o_dout_valid,
    output logic signed [fir_num_pkg::DATA_W-1:0] o_dout
);
    import fir_num_pkg::*;

    // Sequencer to memories
    logic                     mem_we;
    logic [ADDR_W-1:0]        mem_waddr;
    logic signed [DATA_W-1:0] mem_wdata;
    logic                     mem_re;       // Shared by both memories
    logic [ADDR_W-1:0]        sample_raddr;
    logic [ADDR_W-1:0]        coef_addr;

    // Memories and sequencer to tap
    logic signed [DATA_W-1:0] sample_rdata;
    logic signed [COEF_W-1:0] coef_rdata;
    logic                     tap_clear;
    logic                     tap_acc_en;
    logic                     tap_take;

    fir_seq_ctrl fir_seq_ctrl_inst (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_din_valid  (i_din_valid),
        .i_din        (i_din),
        .o_in_credit  (o_in_credit),
        .i_out_credit (i_out_credit),
        .o_dout_valid (o_dout_valid),
        .o_we         (mem_we),
        .o_waddr      (mem_waddr),
        .o_wdata      (mem_wdata),
        .o_re         (mem_re),
        .o_raddr      (sample_raddr),
        .o_coef_addr  (coef_addr),
        .o_clear      (tap_clear),
        .o_acc_en     (tap_acc_en),
        .o_take       (tap_take)
    );

    fir_sample_ram fir_sample_ram_inst (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_we    (mem_we),
        .i_waddr (mem_waddr),
        .i_wdata (mem_wdata),
        .i_re    (mem_re),
        .i_raddr (sample_raddr),
        .o_rdata (sample_rdata)
    );

    fir_coef_rom fir_coef_rom_inst (
        .i_clk  (i_clk),
        .i_re   (mem_re),
        .i_addr (coef_addr),
        .o_coef (coef_rdata)
    );

    // o_dout comes straight from the tap's result register
    fir_mac_tap fir_mac_tap_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_clear  (tap_clear),
        .i_acc_en (tap_acc_en),
        .i_sample (sample_rdata),
        .i_coef   (coef_rdata),
        .i_take   (tap_take),
        .o_result (o_dout)
    );

endmodule

/* rtl/fir_mac_tap.sv */
module fir_mac_tap (
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  logic                                  i_clear,   // First tap, load instead of add
    input  logic                                  i_acc_en,  // Memory data valid this cycle
    input  logic signed [fir_num_pkg::DATA_W-1:0] i_sample,
    input  logic signed [fir_num_pkg::COEF_W-1:0] i_coef,
    input  logic                                  i_take,    // Accumulator holds the full sum
    output logic signed [fir_num_pkg::DATA_W-1:0] o_result
);
    import fir_num_pkg::*;

    logic signed [DATA_W+COEF_W-1:0] prod;       // Full precision product
    logic signed [ACC_W-1:0]         prod_ext;   // Sign extended to accumulator width
    logic signed [ACC_W-1:0]         acc;
    logic signed [ACC_W-1:0]         shifted;    // Back to sample scale
    logic [ACC_W-DATA_W:0]           hi_bits;    // Sign bit of result and everything above
    logic signed [DATA_W-1:0]        sat_val;

    assign prod     = i_sample * i_coef;
    assign prod_ext = prod;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            acc <= '0;
        end else if (i_acc_en) begin
            if (i_clear) begin
                acc <= prod_ext;              // Drop the previous sample's sum
            end else begin
                acc <= acc + prod_ext;
            end
        end
    end

    // Floor division by 2^COEF_FRAC, low bits simply fall off
    assign shifted = acc >>> COEF_FRAC;
    assign hi_bits = shifted[ACC_W-1:DATA_W-1];

    // In range only when all upper bits agree with the result sign
    always_comb begin
        if ((&hi_bits) || !(|hi_bits)) begin
            sat_val = shifted[DATA_W-1:0];
        end else begin
            sat_val = {shifted[ACC_W-1], {(DATA_W-1){~shifted[ACC_W-1]}}};  // Clip to max or min
        end
    end

    // Held until the next take
    always_ff @(posedge i_clk) begin
        if (i_take) begin
            o_result <= sat_val;
        end
    end

endmodule

/* rtl/fir_num_pkg.sv */
package fir_num_pkg;

    // Sample and result word, signed
    localparam int DATA_W = 24;

    // Coefficient word, signed Q1.15
    localparam int COEF_W    = 16;
    localparam int COEF_FRAC = 15;  // Fraction bits dropped after the sum

    // 40-bit products plus 4 growth bits for 16 taps, rest is headroom
    localparam int ACC_W = 48;

    // Tap count, must stay a power of two for the circular pointer
    localparam int FIR_DEPTH = 16;
    localparam int ADDR_W    = $clog2(FIR_DEPTH);

    // Coefficient image, shared by the ROM and the testbench model
    localparam string COEF_FILE = "rtl/weights.mem";

endpackage

/* rtl/fir_sample_ram.sv */
module fir_sample_ram (
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  logic                                  i_we,
    input  logic [fir_num_pkg::ADDR_W-1:0]        i_waddr,
    input  logic signed [fir_num_pkg::DATA_W-1:0] i_wdata,
    input  logic                                  i_re,
    input  logic [fir_num_pkg::ADDR_W-1:0]        i_raddr,
    output logic signed [fir_num_pkg::DATA_W-1:0] o_rdata
);
    import fir_num_pkg::*;

    logic signed [DATA_W-1:0] mem [FIR_DEPTH];  // Sample history, newest at the pointer

    // Reset zeroes the history so the first outputs see silence before sample zero
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < FIR_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Registered read, one cycle behind i_re
    always_ff @(posedge i_clk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];  // Old word if same address is being written
        end
    end

endmodule

/* rtl/fir_seq_ctrl.sv */
module fir_seq_ctrl (
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  logic                                  i_din_valid,
    input  logic signed [fir_num_pkg::DATA_W-1:0] i_din,
    output logic                                  o_in_credit,
    input  logic                                  i_out_credit,
    output logic                                  o_dout_valid,
    output logic                                  o_we,
    output logic [fir_num_pkg::ADDR_W-1:0]        o_waddr,
    output logic signed [fir_num_pkg::DATA_W-1:0] o_wdata,
    output logic                                  o_re,
    output logic [fir_num_pkg::ADDR_W-1:0]        o_raddr,
    output logic [fir_num_pkg::ADDR_W-1:0]        o_coef_addr,
    output logic                                  o_clear,
    output logic                                  o_acc_en,
    output logic                                  o_take
);
    import fir_num_pkg::*;
    import fir_ctl_pkg::*;

    seq_state_t               state;
    seq_state_t               next_state;
    logic [ADDR_W-1:0]        newest_ptr;   // Slot of x[n], moves down one per sample
    logic [ADDR_W-1:0]        tap_cnt;      // Tap index k during S_TAPS
    logic                     drain_cnt;    // Second drain cycle when set
    logic                     last_tap;
    logic                     hold_full;    // Holding register owns a sample
    logic signed [DATA_W-1:0] hold_data;
    logic [CREDIT_W-1:0]      credit_cnt;   // Output credits granted by the sink

    assign last_tap = (tap_cnt == ADDR_W'(FIR_DEPTH - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:  if (hold_full) next_state = S_WRITE;
            S_WRITE: next_state = S_TAPS;                      // Always a single cycle
            S_TAPS:  if (last_tap) next_state = S_DRAIN;
            S_DRAIN: if (drain_cnt) next_state = S_EMIT;       // Two cycles
            S_EMIT:  if (credit_cnt != '0) next_state = S_IDLE; // Stalls under back-pressure
            default: next_state = S_IDLE;
        endcase
    end

    // Pointer and per-state counters
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            newest_ptr <= '0;
            tap_cnt    <= '0;
            drain_cnt  <= 1'b0;
        end else begin
            if (state == S_WRITE) begin
                newest_ptr <= newest_ptr - ADDR_W'(1);  // Wraps modulo FIR_DEPTH
            end
            tap_cnt   <= (state == S_TAPS) ? tap_cnt + ADDR_W'(1) : '0;
            drain_cnt <= (state == S_DRAIN) ? ~drain_cnt : 1'b0;
        end
    end

    // One-entry holding register, may refill while taps run
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            hold_full <= 1'b0;
        end else if (i_din_valid) begin
            hold_full <= 1'b1;
        end else if (state == S_WRITE) begin
            hold_full <= 1'b0;  // Sample moved into history
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_din_valid) begin
            hold_data <= i_din;
        end
    end

    // Sink grants add, each emitted result spends one
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            credit_cnt <= '0;
        end else begin
            case ({i_out_credit, o_dout_valid})
                2'b10:   credit_cnt <= credit_cnt + CREDIT_W'(1);
                2'b01:   credit_cnt <= credit_cnt - CREDIT_W'(1);
                default: credit_cnt <= credit_cnt;  // Both or neither
            endcase
        end
    end

    // Tap controls follow the memory read by one cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_clear  <= 1'b0;
            o_acc_en <= 1'b0;
        end else begin
            o_clear  <= (state == S_TAPS) && (tap_cnt == '0);  // Lines up with tap 0 data
            o_acc_en <= (state == S_TAPS);
        end
    end

    assign o_we        = (state == S_WRITE);
    assign o_in_credit = (state == S_WRITE);      // Credit back as the sample leaves
    assign o_waddr     = newest_ptr - ADDR_W'(1); // Slot the pointer moves to
    assign o_wdata     = hold_data;

    // Tap k pairs h[k] with x[n-k]
    assign o_re        = (state == S_TAPS);
    assign o_raddr     = newest_ptr + tap_cnt;
    assign o_coef_addr = tap_cnt;

    // Last product lands in the first drain cycle, sum is complete in the second
    assign o_take       = (state == S_DRAIN) && drain_cnt;
    assign o_dout_valid = (state == S_EMIT) && (credit_cnt != '0);

endmodule

/* rtl/weights.mem */
// Q1.15 coefficient h[k] in hex, one per line, h[0] first
FE0C
FC18
0064
07D0
0FA0
1770
1B58
2000
1F40
1B58
1770
0FA0
07D0
0064
FC18
FE0C

/* tests/fir_filter_chk.sv */
module fir_filter_chk (
    input logic                               i_clk,
    input logic                               i_rst,
    input logic                               i_din_valid,
    input logic                               i_hold_full,
    input fir_ctl_pkg::seq_state_t            i_state,
    input logic                               i_in_credit,
    input logic                               i_out_credit,
    input logic                               i_dout_valid,
    input logic [fir_ctl_pkg::CREDIT_W-1:0]   i_credit_cnt
);
    import fir_ctl_pkg::*;

    logic [CREDIT_W-1:0] open_credits;  // Grants not yet spent, counted from the ports

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            open_credits <= '0;
        end else begin
            open_credits <= open_credits + CREDIT_W'(i_out_credit) - CREDIT_W'(i_dout_valid);
        end
    end

    // A result only leaves against a granted credit
    a_dout_credit: assert property (@(posedge i_clk) disable iff (i_rst)
        i_dout_valid |-> (open_credits != '0))
        else $error("o_dout_valid raised with no output credit");

    // One credit back per stored sample
    a_credit_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        i_in_credit |=> !i_in_credit)
        else $error("o_in_credit held for more than one cycle");

    // Refill allowed in the write cycle, the old sample leaves on the same edge
    a_hold_free: assert property (@(posedge i_clk) disable iff (i_rst)
        i_din_valid |-> (!i_hold_full || i_state == S_WRITE))
        else $error("Sample arrived while the holding register was full");

    a_credit_max: assert property (@(posedge i_clk) disable iff (i_rst)
        i_credit_cnt <= CREDIT_W'(OUT_CREDITS))
        else $error("Output credit count above its limit");  // Sink overgranted

endmodule

bind fir_seq_ctrl fir_filter_chk fir_filter_chk_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_din_valid  (i_din_valid),
    .i_hold_full  (hold_full),
    .i_state      (state),
    .i_in_credit  (o_in_credit),
    .i_out_credit (i_out_credit),
    .i_dout_valid (o_dout_valid),
    .i_credit_cnt (credit_cnt)
);

/* tests/fir_filter_tb.sv */
module fir_filter_tb;
    import fir_num_pkg::*;
    import fir_ctl_pkg::*;

    localparam int NUM_STIM   = 80;
    localparam int LOOP_LIMIT = NUM_STIM * 100;  // Cycles for the whole table
    localparam int IDLE_WAIT  = 20;              // Quiet cycles after reset and at the end
    localparam logic signed [DATA_W-1:0] FULL_POS = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic signed [DATA_W-1:0] FULL_NEG = {1'b1, {(DATA_W-1){1'b0}}};

    typedef struct {
        logic signed [DATA_W-1:0] sample;
        int                       gap;  // Cycles the sink holds back this result's credit
        logic signed [DATA_W-1:0] exp;  // Model output for this sample
    } stim_t;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     din_valid;
    logic signed [DATA_W-1:0] din;
    logic                     in_credit;
    logic                     out_credit;
    logic                     dout_valid;
    logic signed [DATA_W-1:0] dout;

    stim_t                    stim [NUM_STIM];
    logic signed [COEF_W-1:0] h_ref [FIR_DEPTH];
    longint                   hist [FIR_DEPTH];  // hist[k] is x[n-k]
    logic [CREDIT_W-1:0]      src_credits;       // Credits the source holds
    int                       fill_idx;
    int                       sent;
    int                       returned;          // o_in_credit pulses seen
    int                       granted;           // i_out_credit pulses given
    int                       recv;
    int                       gap_left;
    int                       cycles;

    fir_filter_top fir_filter_top_inst (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_din_valid  (din_valid),
        .i_din        (din),
        .o_in_credit  (in_credit),
        .i_out_credit (out_credit),
        .o_dout_valid (dout_valid),
        .o_dout       (dout)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_result(input logic signed [DATA_W-1:0] got,
                                input logic signed [DATA_W-1:0] exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: result %0d is %0d, expected %0d",
                                $time, idx, got, exp));
        end
    endtask

    task automatic check_credits(input logic [CREDIT_W-1:0] got,
                                 input logic [CREDIT_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: source holds %0d input credits, expected %0d",
                                $time, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Direct form sum, floor shift, then clip to the sample range
    function automatic logic signed [DATA_W-1:0] model_step(input logic signed [DATA_W-1:0] x);
        longint acc;
        longint lim_hi;
        longint lim_lo;
        lim_hi = (longint'(1) <<< (DATA_W - 1)) - 1;
        lim_lo = -(longint'(1) <<< (DATA_W - 1));
        for (int k = FIR_DEPTH - 1; k > 0; k--) begin
            hist[k] = hist[k - 1];  // Age the line by one sample
        end
        hist[0] = longint'(x);
        acc = 0;
        for (int k = 0; k < FIR_DEPTH; k++) begin
            acc += hist[k] * longint'(h_ref[k]);
        end
        acc = acc >>> COEF_FRAC;
        if (acc > lim_hi) acc = lim_hi;
        if (acc < lim_lo) acc = lim_lo;
        return DATA_W'(acc);
    endfunction

    function automatic void add_entry(input logic signed [DATA_W-1:0] x, input int gap);
        stim[fill_idx].sample = x;
        stim[fill_idx].gap    = gap;
        stim[fill_idx].exp    = model_step(x);
        fill_idx++;
    endfunction

    function automatic void build_table();
        for (int k = 0; k < FIR_DEPTH; k++) begin  // Unit impulse in Q1.15, credits in bursts
            add_entry((k == 0) ? DATA_W'(1 << COEF_FRAC) : DATA_W'(0), 0);
        end
        for (int k = 0; k < 24; k++) begin
            add_entry(DATA_W'($urandom), int'($urandom_range(5, 0)));
        end
        for (int k = 0; k < 16; k++) add_entry(FULL_POS, 1);  // Runs into the upper clip
        for (int k = 0; k < 16; k++) add_entry(FULL_NEG, 2);
        for (int k = 0; k < 8; k++) begin  // Long back-pressure, source must stall
            add_entry(DATA_W'($urandom), 30 + int'($urandom_range(20, 0)));
        end
    endfunction

    initial begin
        rst        = 1'b1;
        din_valid  = 1'b0;
        din        = '0;
        out_credit = 1'b0;
        void'($urandom(32'haa2b));
        $readmemh(COEF_FILE, h_ref);
        for (int k = 0; k < FIR_DEPTH; k++) hist[k] = 0;
        fill_idx = 0;
        build_table();
        src_credits = CREDIT_W'(IN_CREDITS);
        sent     = 0;
        returned = 0;
        granted  = 0;
        recv     = 0;
        cycles   = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        for (int c = 0; c < IDLE_WAIT; c++) begin  // Nothing moves before the first sample
            @(negedge clk);
            check_flag(dout_valid, 1'b0, "o_dout_valid after reset");
            if (in_credit) begin
                src_credits = src_credits + CREDIT_W'(1);  // Spare credit with nothing sent
            end
        end
        check_credits(src_credits, CREDIT_W'(IN_CREDITS));

        gap_left = stim[0].gap;
        while (recv < NUM_STIM) begin
            @(negedge clk);
            cycles++;
            if (cycles > LOOP_LIMIT) begin
                abort_run($sformatf("Timeout: only %0d of %0d results came back in %0d cycles",
                                    recv, NUM_STIM, LOOP_LIMIT));
            end
            if (in_credit) begin
                if (returned >= sent) begin
                    abort_run($sformatf("Error at %0t: input credit with no sample taken", $time));
                end
                returned++;
                src_credits = src_credits + CREDIT_W'(1);
            end
            if (dout_valid) begin
                if (granted == recv) begin
                    abort_run($sformatf("Error at %0t: result with no output credit", $time));
                end
                if (recv < FIR_DEPTH) check_result(dout, DATA_W'(h_ref[recv]), recv);  // h[k]
                check_result(dout, stim[recv].exp, recv);
                recv++;
            end
            din_valid  = 1'b0;
            out_credit = 1'b0;
            if (src_credits != '0 && sent < NUM_STIM) begin  // Spend one credit per sample
                din_valid   = 1'b1;
                din         = stim[sent].sample;
                src_credits = src_credits - CREDIT_W'(1);
                sent++;
            end
            if (granted < NUM_STIM) begin
                if (gap_left > 0) begin
                    gap_left--;
                end else if (granted - recv < OUT_CREDITS) begin
                    out_credit = 1'b1;
                    granted++;
                    if (granted < NUM_STIM) gap_left = stim[granted].gap;
                end
            end
        end

        for (int c = 0; c < IDLE_WAIT; c++) begin  // No extra results or credits
            @(negedge clk);
            check_flag(dout_valid, 1'b0, "o_dout_valid after the last result");
            check_flag(in_credit, 1'b0, "o_in_credit after the last sample");
        end
        check_credits(src_credits, CREDIT_W'(IN_CREDITS));

        $display("TEST PASSED");
        $finish;
    end

endmodule
